// ==== source/prefix_adder_pkg.sv ====
package prefix_adder_pkg;

    //////////////////////////////////////////////////
    // adder geometry
    //////////////////////////////////////////////////

    // operand width and tree depth, log2 of the width
    localparam int data_width    = 32;
    localparam int prefix_levels = 5;

    // registers between operand sampling and the sum
    localparam int pipe_stages   = 3;

    // only the upper part of the sum goes back to the divider
    localparam int sum_lsb       = 6;
    localparam int sum_width     = data_width - sum_lsb;

    //////////////////////////////////////////////////
    // divider iteration state
    //////////////////////////////////////////////////

    localparam int count_width       = 3;
    localparam int remain_width      = 10;
    localparam int operand_tag_width = 25;

    //////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////

    typedef logic [data_width-1:0] operand_t;

    // bits sum_lsb and up of the full sum
    typedef logic [sum_width-1:0] sum_slice_t;

    // generate/propagate vector between prefix stages
    typedef struct packed {
        // group generate, grows with each level
        logic [data_width-1:0] gen;
        // group propagate
        logic [data_width-1:0] prop;
        // a xor b per bit, kept for the final sum
        logic [data_width-1:0] bit_prop;
    } pg_vec_t;

    // state that rides alongside the addition
    typedef struct packed {
        logic [count_width-1:0]       iter_count;
        logic                         done;
        logic [remain_width-1:0]      remain_count;
        logic [operand_tag_width-1:0] f_val;
        logic [operand_tag_width-1:0] n_val;
        logic [operand_tag_width-1:0] d_val;
    } sideband_t;

endpackage

// ==== source/prefix_stage.sv ====
`timescale 1ns/10ps

module prefix_stage
    import prefix_adder_pkg::*;
#(
    // lowest tree level handled here
    parameter int first_level = 0,
    // number of consecutive levels before the register
    parameter int level_count = 1
) (
    input  logic    clk,
    input  logic    rst,
    input  pg_vec_t pg_in,
    output pg_vec_t pg_out
);

    //////////////////////////////////////////////////
    // index helpers
    //////////////////////////////////////////////////

    // top bit of the lower half of the aligned block
    // that holds bit_idx, block size 2**(level+1)
    function automatic int low_index(input int bit_idx, input int level);
        int block_base;
        block_base = (bit_idx >> (level + 1)) << (level + 1);
        return block_base + (1 << level) - 1;
    endfunction

    // true for bits in the upper half of their block
    function automatic bit in_upper_half(input int bit_idx, input int level);
        return ((bit_idx >> level) & 1) == 1;
    endfunction

    //////////////////////////////////////////////////
    // combine levels
    //////////////////////////////////////////////////

    // entry 0 is the stage input, entry level_count feeds the register
    pg_vec_t lvl [level_count+1];

    always_comb begin
        int cur_level;
        int lo;

        lvl[0] = pg_in;
        for (int l = 0; l < level_count; l++) begin
            cur_level = first_level + l;

            // default pass-through, bit_prop is never touched
            lvl[l+1] = lvl[l];

            for (int i = 0; i < data_width; i++) begin
                if (in_upper_half(i, cur_level)) begin
                    lo = low_index(i, cur_level);
                    lvl[l+1].gen[i]  = lvl[l].gen[i]
                                     | (lvl[l].prop[i] & lvl[l].gen[lo]);
                    lvl[l+1].prop[i] = lvl[l].prop[i] & lvl[l].prop[lo];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // pipeline register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            pg_out <= '0;
        end else begin
            pg_out <= lvl[level_count];
        end
    end

endmodule

// ==== source/sideband_delay.sv ====
`timescale 1ns/10ps

module sideband_delay
    import prefix_adder_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  sideband_t side_in,
    output sideband_t side_out
);

    //////////////////////////////////////////////////
    // delay line
    //////////////////////////////////////////////////

    // one entry per adder stage
    sideband_t side_pipe [pipe_stages];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < pipe_stages; i++) begin
                side_pipe[i] <= '0;
            end
        end else begin
            side_pipe[0] <= side_in;
            // shift toward the output
            for (int i = 1; i < pipe_stages; i++) begin
                side_pipe[i] <= side_pipe[i-1];
            end
        end
    end

    // oldest entry lines up with the sum slice
    assign side_out = side_pipe[pipe_stages-1];

endmodule

// ==== source/prefix_adder_core.sv ====
`timescale 1ns/10ps

module prefix_adder_core
    import prefix_adder_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  operand_t   a,
    input  operand_t   b,
    output sum_slice_t sum
);

    // bitwise encode, not registered
    pg_vec_t  pg_enc;

    // registered outputs of each stage
    pg_vec_t  pg_s1;
    pg_vec_t  pg_s2;
    pg_vec_t  pg_s3;

    // carries into each bit position
    operand_t carry_in;

    // full sum before slicing
    operand_t full_sum;

    //////////////////////////////////////////////////
    // generate / propagate per bit
    //////////////////////////////////////////////////

    always_comb begin
        pg_enc.gen      = a & b;
        pg_enc.prop     = a ^ b;
        pg_enc.bit_prop = a ^ b;
    end

    //////////////////////////////////////////////////
    // prefix tree, three register stages
    //////////////////////////////////////////////////

    // level 0 only, short stage ahead of the encode logic
    prefix_stage #(
        .first_level (0),
        .level_count (1)
    ) i_stage1 (
        .clk    (clk),
        .rst    (rst),
        .pg_in  (pg_enc),
        .pg_out (pg_s1)
    );

    // levels 1 and 2
    prefix_stage #(
        .first_level (1),
        .level_count (2)
    ) i_stage2 (
        .clk    (clk),
        .rst    (rst),
        .pg_in  (pg_s1),
        .pg_out (pg_s2)
    );

    // remaining levels, 3 and 4
    prefix_stage #(
        .first_level (3),
        .level_count (prefix_levels - 3)
    ) i_stage3 (
        .clk    (clk),
        .rst    (rst),
        .pg_in  (pg_s2),
        .pg_out (pg_s3)
    );

    //////////////////////////////////////////////////
    // sum formation
    //////////////////////////////////////////////////

    // gen at i-1 is the carry into bit i, carry-in of bit 0 is zero
    always_comb begin
        carry_in[0] = 1'b0;
        for (int i = 1; i < data_width; i++) begin
            carry_in[i] = pg_s3.gen[i-1];
        end
    end

    // carry out of the top bit is dropped
    assign full_sum = pg_s3.bit_prop ^ carry_in;

    // low bits are not needed by the divider
    assign sum = full_sum[data_width-1:sum_lsb];

endmodule

// ==== source/prefix_adder_top.sv ====
`timescale 1ns/10ps

module prefix_adder_top
    import prefix_adder_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // operands, one pair per clock
    input  operand_t   a,
    input  operand_t   b,

    // divider state for this pair
    input  sideband_t  side_in,

    // upper slice of a + b, pipe_stages clocks later
    output sum_slice_t sum,

    // divider state, same latency as sum
    output sideband_t  side_out
);

    //////////////////////////////////////////////////
    // arithmetic path
    //////////////////////////////////////////////////

    prefix_adder_core i_core (
        .clk (clk),
        .rst (rst),
        .a   (a),
        .b   (b),
        .sum (sum)
    );

    //////////////////////////////////////////////////
    // state path
    //////////////////////////////////////////////////

    // depth matches the core, so both leave together
    sideband_delay i_side (
        .clk      (clk),
        .rst      (rst),
        .side_in  (side_in),
        .side_out (side_out)
    );

endmodule

// ==== dv/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: operand a, operand b, expected sum bits 31 down to 6
// expected column is ((a + b) mod 2**32) >> 6

localparam int num_vectors = 24;

localparam vector_t vectors [num_vectors] = '{
    // short carries, all below bit 6
    '{32'h0000_0000, 32'h0000_0000, 26'h000_0000},
    '{32'h0000_0001, 32'h0000_0001, 26'h000_0000},
    '{32'h0000_001f, 32'h0000_001f, 26'h000_0000},
    '{32'h0000_0020, 32'h0000_001f, 26'h000_0000},
    '{32'h0000_0030, 32'h0000_000f, 26'h000_0000},
    // carry into bit 6
    '{32'h0000_0020, 32'h0000_0020, 26'h000_0001},
    '{32'h0000_003f, 32'h0000_0001, 26'h000_0001},
    // low-order noise leaves the slice alone
    '{32'h0000_0040, 32'h0000_0005, 26'h000_0001},
    '{32'h1000_0000, 32'h0000_0003, 26'h040_0000},
    // full-width chains
    '{32'hffff_ffff, 32'h0000_0001, 26'h000_0000},
    '{32'hffff_ffff, 32'hffff_ffff, 26'h3ff_ffff},
    '{32'haaaa_aaaa, 32'h5555_5555, 26'h3ff_ffff},
    '{32'haaaa_aaaa, 32'h5555_5556, 26'h000_0000},
    '{32'h5555_5555, 32'h5555_5555, 26'h2aa_aaaa},
    '{32'haaaa_aaaa, 32'haaaa_aaaa, 26'h155_5555},
    '{32'h7fff_ffff, 32'h0000_0001, 26'h200_0000},
    '{32'h0000_ffff, 32'h0000_0001, 26'h000_0400},
    '{32'h00ff_ffc0, 32'h0000_0040, 26'h004_0000},
    '{32'hffff_ffc0, 32'h0000_0040, 26'h000_0000},
    '{32'h8000_0000, 32'h8000_0000, 26'h000_0000},
    // mixed patterns
    '{32'h1234_5678, 32'h8765_4321, 26'h266_6666},
    '{32'hdead_beef, 32'h2152_4111, 26'h000_0000},
    '{32'h0f0f_0f0f, 32'h00f0_f0f1, 26'h040_0000},
    '{32'hffff_ffff, 32'h0000_0000, 26'h3ff_ffff}
};

`endif

// ==== dv/tb_prefix_adder.sv ====
`timescale 1ns/10ps

module tb_prefix_adder
    import prefix_adder_pkg::*;
();

    //////////////////////////////////////////////////
    // run parameters
    //////////////////////////////////////////////////

    localparam int reset_cycles = 4;
    localparam int num_random   = 64;
    localparam int rand_seed    = 32'hc81c_e858;

    // directed row with operands and the kept sum slice
    typedef struct packed {
        operand_t   a;
        operand_t   b;
        sum_slice_t exp_sum;
    } vector_t;

    // one item in flight through the DUT
    typedef struct packed {
        int unsigned idx;
        sum_slice_t  sum;
        sideband_t   side;
    } expect_t;

    `include "tb_vectors.svh"

    localparam int timeout_limit =
        reset_cycles + num_vectors + num_random + pipe_stages + 20;

    logic       clk;
    logic       rst;
    operand_t   a;
    operand_t   b;
    sideband_t  side_in;
    sum_slice_t sum;
    sideband_t  side_out;

    expect_t     exp_q [$];
    int          checks_done = 0;
    int          cycle_count = 0;
    int unsigned item_count  = 0;

    prefix_adder_top i_dut (
        .clk      (clk),
        .rst      (rst),
        .a        (a),
        .b        (b),
        .side_in  (side_in),
        .sum      (sum),
        .side_out (side_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // hard stop if the item loop never drains
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////
    // reference model and compare tasks
    //////////////////////////////////////////////////

    // modular sum with the low bits dropped
    function automatic sum_slice_t expected_slice(input operand_t x, input operand_t y);
        operand_t total;
        total = x + y;
        return total[data_width-1:sum_lsb];
    endfunction

    function automatic sideband_t random_sideband();
        sideband_t s;
        s.iter_count   = count_width'($urandom());
        s.done         = 1'($urandom());
        s.remain_count = remain_width'($urandom());
        s.f_val        = operand_tag_width'($urandom());
        s.n_val        = operand_tag_width'($urandom());
        s.d_val        = operand_tag_width'($urandom());
        return s;
    endfunction

    task automatic check_sum(input int unsigned idx, input sum_slice_t actual,
                             input sum_slice_t expected);
        checks_done++;
        if (actual !== expected) begin
            $display("[FAIL] sum (item %0d): got 0x%h, expected 0x%h", idx, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "sum mismatch");
        end
    endtask

    task automatic check_sideband(input int unsigned idx, input sideband_t actual,
                                  input sideband_t expected);
        checks_done++;
        if (actual !== expected) begin
            $display("[FAIL] side_out (item %0d): got 0x%h, expected 0x%h",
                     idx, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "sideband mismatch");
        end
    endtask

    task automatic check_oldest();
        expect_t item;
        item = exp_q.pop_front();
        check_sum(item.idx, sum, item.sum);
        check_sideband(item.idx, side_out, item.side);
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // called on a falling edge and returns on the next one
    task automatic apply_item(input operand_t op_a, input operand_t op_b,
                              input sum_slice_t exp_sum);
        expect_t item;
        if (exp_q.size() == pipe_stages) begin
            check_oldest();
        end else begin
            // outputs still hold the reset value while the pipeline fills
            check_sum(item_count, sum, '0);
            check_sideband(item_count, side_out, '0);
        end
        item.idx  = item_count;
        item.sum  = exp_sum;
        item.side = random_sideband();
        a       = op_a;
        b       = op_b;
        side_in = item.side;
        exp_q.push_back(item);
        item_count++;
        @(negedge clk);
    endtask

    initial begin
        operand_t ra;
        operand_t rb;

        void'($urandom(rand_seed));

        // junk on the inputs while reset is held
        rst     = 1'b0;
        a       = $urandom();
        b       = $urandom();
        side_in = random_sideband();
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        for (int n = 0; n < num_vectors; n++) begin
            apply_item(vectors[n].a, vectors[n].b, vectors[n].exp_sum);
        end

        for (int n = 0; n < num_random; n++) begin
            ra = $urandom();
            rb = $urandom();
            apply_item(ra, rb, expected_slice(ra, rb));
        end

        while (exp_q.size() > 0) begin
            check_oldest();
            @(negedge clk);
        end

        $display("%0d items, %0d compares", item_count, checks_done);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+dv
source/prefix_adder_pkg.sv
source/prefix_stage.sv
source/sideband_delay.sv
source/prefix_adder_core.sv
source/prefix_adder_top.sv
dv/tb_prefix_adder.sv

// ==== Makefile ====
# Verilator flow for the prefix adder testbench
# any variable can be overridden, e.g. make run LOG=other.log

VERILATOR   ?= verilator
TOP         ?= tb_prefix_adder
FILELIST    ?= filelist.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
PASS_TEXT   ?= ALL CHECKS PASSED
VFLAGS      ?= --binary --timing
EXTRA_FLAGS ?=

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := dv/tb_vectors.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) \
		--top-module $(TOP) \
		--Mdir $(BUILD_DIR) \
		-f $(FILELIST)

# the log decides the result, not the exit status
run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -qF "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, exit status $$status"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
